//--- src/div_consts.svh
//////////////////////////////////////////////////
// divide unit constants
// data width, iteration counter width, fault codes
// and the bit positions inside the condition flags
//////////////////////////////////////////////////
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// width of numerator, denominator and quotient
`define DIV_BW 32
// the iteration counter has to hold the value DIV_BW itself
`define DIV_CNT_W 6

// fault codes carried from operand preparation to the formatter
`define DIV_FAULT_NONE 2'b00
`define DIV_FAULT_ZERO 2'b01
`define DIV_FAULT_OVF  2'b10

// condition flag bit positions
`define DIV_FLAG_ZERO 0
`define DIV_FLAG_NEG  1
`define DIV_FLAG_OVF  2

`endif

//--- src/div_pkg.sv
//////////////////////////////////////////////////
// divide unit package
// word, counter, flag and fault types, plus the
// states of the shift-subtract FSM
//////////////////////////////////////////////////
`include "div_consts.svh"

package div_pkg;

	// one data word, used for operands and for the quotient
	typedef logic [`DIV_BW-1:0] div_word_t;

	// remaining iterations of the shift-subtract core
	typedef logic [`DIV_CNT_W-1:0] div_count_t;

	// condition flags, bit 0 zero, bit 1 negative, bit 2 overflow
	typedef logic [2:0] div_flags_t;

	// none, divide by zero or signed overflow
	typedef logic [1:0] div_fault_t;

	// the core is either waiting for a start pulse or iterating
	typedef enum logic {
		CORE_IDLE,
		CORE_RUN
	} core_state_t;

endpackage

//--- src/div_ifs.sv
//////////////////////////////////////////////////
// divide unit internal buses
// operands into the shift-subtract core, results out of it
//////////////////////////////////////////////////

// prepared unsigned operands plus the side information that
// the core only carries through to the formatter
interface div_operand_if;
	logic                start;
	div_pkg::div_word_t  dividend;
	div_pkg::div_word_t  divisor;
	logic                negate;
	div_pkg::div_fault_t fault;

	// start is a single cycle pulse, the rest is valid with it
	modport prep (output start, output dividend, output divisor,
		output negate, output fault);
	modport core (input start, input dividend, input divisor,
		input negate, input fault);
endinterface

// raw quotient from the core with the carried side information
interface div_result_if;
	logic                done;
	div_pkg::div_word_t  quotient;
	logic                negate;
	div_pkg::div_fault_t fault;

	// done is a single cycle pulse, the rest is valid with it
	modport core (output done, output quotient, output negate,
		output fault);
	modport fmt (input done, input quotient, input negate,
		input fault);

	// the input stage only needs to know when a divide finishes,
	// so that it can release busy
	modport done_watch (input done);
endinterface

//--- src/div_operand_prep.sv
//////////////////////////////////////////////////
// divide operand preparation
// accepts a request, owns busy, and turns the operands
// into magnitudes with sign and fault side information
//////////////////////////////////////////////////
`include "div_consts.svh"

module div_operand_prep (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_wr,
	input  logic                  i_signed,
	input  div_pkg::div_word_t    i_numerator,
	input  div_pkg::div_word_t    i_denominator,
	output logic                  o_busy,
	div_operand_if.prep           o_operand,
	div_result_if.done_watch      i_result
);
	import div_pkg::*;

	logic       r_busy;
	logic       w_accept;
	logic       w_num_neg;
	logic       w_den_neg;
	div_word_t  w_num_abs;
	div_word_t  w_den_abs;
	div_fault_t w_fault;

	//////////////////////////////////////////////////
	// request decode
	//////////////////////////////////////////////////

	// a write while busy is simply dropped, the requester
	// is expected to wait on o_busy
	assign w_accept = i_wr && !r_busy;

	// operand signs only count for a signed divide
	assign w_num_neg = i_signed && i_numerator[`DIV_BW-1];
	assign w_den_neg = i_signed && i_denominator[`DIV_BW-1];

	// magnitudes, the most negative value maps onto itself
	// which is still correct read as unsigned
	assign w_num_abs = w_num_neg ? -i_numerator : i_numerator;
	assign w_den_abs = w_den_neg ? -i_denominator : i_denominator;

	// divide by zero wins over overflow, the denominator cannot
	// be zero and minus one at once anyway
	always_comb begin
		if (i_denominator == '0)
			w_fault = `DIV_FAULT_ZERO;
		else if (i_signed && (i_numerator == {1'b1, {(`DIV_BW-1){1'b0}}})
				&& (i_denominator == '1))
			w_fault = `DIV_FAULT_OVF;
		else
			w_fault = `DIV_FAULT_NONE;
	end

	//////////////////////////////////////////////////
	// busy and start
	//////////////////////////////////////////////////

	// busy rises on the edge after acceptance and falls on the
	// edge where the formatter raises o_valid
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			r_busy          <= 1'b0;
			o_operand.start <= 1'b0;
		end else begin
			o_operand.start <= w_accept;
			if (w_accept)
				r_busy <= 1'b1;
			else if (i_result.done)
				r_busy <= 1'b0;
		end
	end

	// prepared operands, held until the next accepted request
	always_ff @(posedge i_clk) begin
		if (w_accept) begin
			o_operand.dividend <= w_num_abs;
			o_operand.divisor  <= w_den_abs;
			o_operand.negate   <= w_num_neg ^ w_den_neg;
			o_operand.fault    <= w_fault;
		end
	end

	assign o_busy = r_busy;

endmodule

//--- src/div_shift_sub.sv
//////////////////////////////////////////////////
// divide shift-subtract core
// restoring unsigned division, one quotient bit per clock
//////////////////////////////////////////////////
`include "div_consts.svh"

module div_shift_sub (
	input  logic         i_clk,
	input  logic         i_reset,
	div_operand_if.core  i_operand,
	div_result_if.core   o_result
);
	import div_pkg::*;

	core_state_t        r_state;
	div_count_t         r_count;
	logic               r_done;
	div_word_t          r_rem;
	div_word_t          r_quo;
	div_word_t          r_divisor;
	logic               r_negate;
	div_fault_t         r_fault;
	logic [`DIV_BW:0]   w_shifted;
	logic [`DIV_BW+1:0] w_diff;
	logic               w_fits;

	//////////////////////////////////////////////////
	// trial subtraction
	//////////////////////////////////////////////////

	// r_quo starts out as the dividend, its top bit is the next
	// dividend bit to bring down, and quotient bits fill it from
	// the bottom as the dividend bits leave at the top
	assign w_shifted = {r_rem, r_quo[`DIV_BW-1]};

	// one extra bit on top so that the borrow can be seen
	assign w_diff = {1'b0, w_shifted} - {2'b00, r_divisor};

	// no borrow means the divisor fits at this bit position
	assign w_fits = !w_diff[`DIV_BW+1];

	//////////////////////////////////////////////////
	// control FSM
	//////////////////////////////////////////////////

	// the counter is loaded on start and the last iteration is
	// the one seen with a count of one
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			r_state <= CORE_IDLE;
			r_count <= '0;
			r_done  <= 1'b0;
		end else begin
			r_done <= 1'b0;
			case (r_state)
			CORE_IDLE: begin
				if (i_operand.start) begin
					r_state <= CORE_RUN;
					r_count <= div_count_t'(`DIV_BW);
				end
			end
			CORE_RUN: begin
				r_count <= r_count - 1'b1;
				if (r_count == div_count_t'(1)) begin
					r_state <= CORE_IDLE;
					r_done  <= 1'b1;
				end
			end
			default: r_state <= CORE_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////

	// a zero divisor always fits, so it ends as an all ones
	// quotient that the formatter throws away
	always_ff @(posedge i_clk) begin
		if ((r_state == CORE_IDLE) && i_operand.start) begin
			r_rem     <= '0;
			r_quo     <= i_operand.dividend;
			r_divisor <= i_operand.divisor;
			r_negate  <= i_operand.negate;
			r_fault   <= i_operand.fault;
		end else if (r_state == CORE_RUN) begin
			// the remainder stays below the divisor so it
			// always fits back into one word
			r_rem <= w_fits ? w_diff[`DIV_BW-1:0] : w_shifted[`DIV_BW-1:0];
			r_quo <= {r_quo[`DIV_BW-2:0], w_fits};
		end
	end

	// done is registered together with the last quotient bit
	assign o_result.done     = r_done;
	assign o_result.quotient = r_quo;
	assign o_result.negate   = r_negate;
	assign o_result.fault    = r_fault;

endmodule

//--- src/div_result_fmt.sv
//////////////////////////////////////////////////
// divide result formatting
// restores the sign, raises the error, builds the flags
//////////////////////////////////////////////////
`include "div_consts.svh"

module div_result_fmt (
	input  logic                  i_clk,
	input  logic                  i_reset,
	div_result_if.fmt             i_result,
	output logic                  o_valid,
	output logic                  o_err,
	output div_pkg::div_word_t    o_quotient,
	output div_pkg::div_flags_t   o_flags
);
	import div_pkg::*;

	logic       w_zero_div;
	logic       w_ovf;
	div_word_t  w_final;
	div_flags_t w_flags;

	assign w_zero_div = (i_result.fault == `DIV_FAULT_ZERO);
	assign w_ovf      = (i_result.fault == `DIV_FAULT_OVF);

	//////////////////////////////////////////////////
	// final quotient
	//////////////////////////////////////////////////

	// an overflow has two negative operands, so negate is clear
	// and the raw magnitude, already the most negative value,
	// passes through as the reported result
	always_comb begin
		if (w_zero_div)
			w_final = '0;
		else if (i_result.negate)
			w_final = -i_result.quotient;
		else
			w_final = i_result.quotient;
	end

	// flags follow the value that is actually returned
	always_comb begin
		w_flags                = '0;
		w_flags[`DIV_FLAG_ZERO] = (w_final == '0);
		w_flags[`DIV_FLAG_NEG]  = w_final[`DIV_BW-1];
		w_flags[`DIV_FLAG_OVF]  = w_ovf;
	end

	//////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////

	// valid is a one cycle copy of done, and error is only
	// ever raised together with valid
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_valid <= 1'b0;
			o_err   <= 1'b0;
		end else begin
			o_valid <= i_result.done;
			o_err   <= i_result.done && w_zero_div;
		end
	end

	// the result stays put until the next divide finishes
	always_ff @(posedge i_clk) begin
		if (i_result.done) begin
			o_quotient <= w_final;
			o_flags    <= w_flags;
		end
	end

endmodule

//--- src/div_unit.sv
//////////////////////////////////////////////////
// iterative integer divide unit
// signed or unsigned quotient with the start, busy and
// valid handshake of the core's execute stage
//////////////////////////////////////////////////

module div_unit (
	input  logic                  i_clk,
	input  logic                  i_reset,
	// request, taken only while o_busy is low
	input  logic                  i_wr,
	input  logic                  i_signed,
	input  div_pkg::div_word_t    i_numerator,
	input  div_pkg::div_word_t    i_denominator,
	// handshake back to the core
	output logic                  o_busy,
	output logic                  o_valid,
	output logic                  o_err,
	// result, meaningful only while o_valid is high
	output div_pkg::div_word_t    o_quotient,
	output div_pkg::div_flags_t   o_flags
);

	//////////////////////////////////////////////////
	// internal buses
	//////////////////////////////////////////////////

	// prepared operands, from the input stage into the core
	div_operand_if operand_bus ();

	// raw quotient, from the core into the formatter, with
	// done also watched by the input stage to release busy
	div_result_if result_bus ();

	//////////////////////////////////////////////////
	// stages
	//////////////////////////////////////////////////

	div_operand_prep prep_inst (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_wr          (i_wr),
		.i_signed      (i_signed),
		.i_numerator   (i_numerator),
		.i_denominator (i_denominator),
		.o_busy        (o_busy),
		.o_operand     (operand_bus.prep),
		.i_result      (result_bus.done_watch)
	);

	// one quotient bit per clock, DIV_BW clocks per divide
	div_shift_sub core_inst (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_operand (operand_bus.core),
		.o_result  (result_bus.core)
	);

	div_result_fmt fmt_inst (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_result   (result_bus.fmt),
		.o_valid    (o_valid),
		.o_err      (o_err),
		.o_quotient (o_quotient),
		.o_flags    (o_flags)
	);

endmodule

//--- tb/div_unit_asserts.sv
//////////////////////////////////////////////////
// divide unit protocol assertions
// bound into div_unit, checks the busy/valid handshake
//////////////////////////////////////////////////

module div_unit_asserts (
	input logic i_clk,
	input logic i_reset,
	input logic i_wr,
	input logic i_busy,
	input logic i_valid,
	input logic i_err
);

	// number of failed assertions, read by the testbench at the end
	int fail_count;

	initial fail_count = 0;

	// a result is never presented while the unit still claims busy
	busy_valid_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_busy && i_valid))
	else begin
		$error("o_busy and o_valid are high in the same cycle");
		fail_count++;
	end

	// valid is a single cycle pulse
	valid_one_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
		i_valid |=> !i_valid)
	else begin
		$error("o_valid stayed high for more than one cycle");
		fail_count++;
	end

	// an accepted write makes the unit busy on the very next cycle
	accept_sets_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_wr && !i_busy) |=> i_busy)
	else begin
		$error("o_busy did not rise on the cycle after an accepted i_wr");
		fail_count++;
	end

	// the error is part of the result and only shows with it
	err_needs_valid: assert property (@(posedge i_clk) disable iff (i_reset)
		i_err |-> i_valid)
	else begin
		$error("o_err is high while o_valid is low");
		fail_count++;
	end

endmodule

bind div_unit div_unit_asserts asserts_inst (
	.i_clk   (i_clk),
	.i_reset (i_reset),
	.i_wr    (i_wr),
	.i_busy  (o_busy),
	.i_valid (o_valid),
	.i_err   (o_err)
);

//--- tb/div_checker.sv
//////////////////////////////////////////////////
// divide unit result checker
// times each request to its o_valid and compares
// the quotient, error and flags with the expected values
//////////////////////////////////////////////////
`include "div_consts.svh"

module div_checker (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_wr,
	input  logic                i_busy,
	input  logic                i_valid,
	input  logic                i_err,
	input  div_pkg::div_word_t  i_quotient,
	input  div_pkg::div_flags_t i_flags,
	input  div_pkg::div_word_t  i_exp_quotient,
	input  logic                i_exp_err,
	input  div_pkg::div_flags_t i_exp_flags,
	input  int                  i_test_id,
	output int                  o_errors,
	output int                  o_results
);
	import div_pkg::*;

	// cycles from the accepting edge to the edge that raises o_valid
	localparam int LATENCY  = `DIV_BW + 2;
	localparam int MAX_WAIT = LATENCY + 16;

	logic       r_pending;
	int         r_cycles;
	int         r_test;
	div_word_t  r_exp_quotient;
	logic       r_exp_err;
	div_flags_t r_exp_flags;

	initial begin
		o_errors  = 0;
		o_results = 0;
		r_pending = 1'b0;
		r_cycles  = 0;
		r_test    = 0;
	end

	//////////////////////////////////////////////////
	// request tracking and comparison
	//////////////////////////////////////////////////

	// everything is sampled on the rising edge, so the values seen
	// are the ones that were stable during the cycle before it
	always @(posedge i_clk) begin
		if (i_reset) begin
			r_pending = 1'b0;
			r_cycles  = 0;
		end else begin
			if (i_valid) begin
				if (!r_pending) begin
					$display("o_valid rose although no request was pending");
					o_errors++;
				end else begin
					if (r_cycles < LATENCY) begin
						$display("line %0d: o_valid came early, %0d cycles after the request",
							r_test, r_cycles);
						o_errors++;
					end else if (r_cycles != LATENCY) begin
						$display("[FAIL] line %0d latency: expected %0d, actual %0d",
							r_test, LATENCY, r_cycles);
						o_errors++;
					end
					if (i_quotient !== r_exp_quotient) begin
						$display("[FAIL] line %0d quotient: expected %h, actual %h",
							r_test, r_exp_quotient, i_quotient);
						o_errors++;
					end
					if (i_err !== r_exp_err) begin
						$display("[FAIL] line %0d err: expected %b, actual %b",
							r_test, r_exp_err, i_err);
						o_errors++;
					end
					if (i_flags !== r_exp_flags) begin
						$display("[FAIL] line %0d flags: expected %b, actual %b",
							r_test, r_exp_flags, i_flags);
						o_errors++;
					end
					o_results++;
				end
				r_pending = 1'b0;
			end else if (r_pending) begin
				r_cycles++;
				if (r_cycles > MAX_WAIT) begin
					$display("line %0d: no o_valid within %0d cycles of the request",
						r_test, MAX_WAIT);
					o_errors++;
					r_pending = 1'b0;
				end
			end

			// the same acceptance rule as the DUT, a write while busy is dropped
			if (i_wr && !i_busy) begin
				r_pending      = 1'b1;
				r_cycles       = 0;
				r_test         = i_test_id;
				r_exp_quotient = i_exp_quotient;
				r_exp_err      = i_exp_err;
				r_exp_flags    = i_exp_flags;
			end
		end
	end

endmodule

//--- tb/tb_div_unit.sv
//////////////////////////////////////////////////
// divide unit testbench
// reads divide vectors from a file, drives them into the
// DUT and hands the expected results to the checker
//////////////////////////////////////////////////
`include "div_consts.svh"

module tb_div_unit;
	import div_pkg::*;

	localparam int IDLE_TIMEOUT   = 100;
	localparam int RESULT_TIMEOUT = 2 * (`DIV_BW + 2);

	logic       i_clk;
	logic       i_reset;
	logic       i_wr;
	logic       i_signed;
	div_word_t  i_numerator;
	div_word_t  i_denominator;
	logic       o_busy;
	logic       o_valid;
	logic       o_err;
	div_word_t  o_quotient;
	div_flags_t o_flags;

	// expected values of the request in flight, for the checker
	div_word_t  exp_quotient;
	logic       exp_err;
	div_flags_t exp_flags;
	int         test_id;

	int         chk_errors;
	int         chk_results;
	int         tb_errors;
	int         assert_errors;
	int         vectors;
	logic       aborted;

	div_unit div_unit_inst (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_wr          (i_wr),
		.i_signed      (i_signed),
		.i_numerator   (i_numerator),
		.i_denominator (i_denominator),
		.o_busy        (o_busy),
		.o_valid       (o_valid),
		.o_err         (o_err),
		.o_quotient    (o_quotient),
		.o_flags       (o_flags)
	);

	div_checker checker_inst (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_wr           (i_wr),
		.i_busy         (o_busy),
		.i_valid        (o_valid),
		.i_err          (o_err),
		.i_quotient     (o_quotient),
		.i_flags        (o_flags),
		.i_exp_quotient (exp_quotient),
		.i_exp_err      (exp_err),
		.i_exp_flags    (exp_flags),
		.i_test_id      (test_id),
		.o_errors       (chk_errors),
		.o_results      (chk_results)
	);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	//////////////////////////////////////////////////
	// helper tasks
	//////////////////////////////////////////////////

	// right after reset the unit must stay quiet
	task automatic check_reset_quiet();
		repeat (4) begin
			@(posedge i_clk);
			if (o_busy !== 1'b0 || o_valid !== 1'b0) begin
				$display("o_busy or o_valid is not low after reset");
				tb_errors++;
			end
		end
	endtask

	task automatic wait_idle(output logic ok);
		int n;
		n  = 0;
		ok = 1'b0;
		while (!ok && n < IDLE_TIMEOUT) begin
			@(posedge i_clk);
			if (o_busy === 1'b0)
				ok = 1'b1;
			n++;
		end
		if (!ok) begin
			$display("timeout: o_busy stayed high for %0d cycles", IDLE_TIMEOUT);
			tb_errors++;
		end
	endtask

	task automatic wait_result(output logic ok);
		int n;
		n  = 0;
		ok = 1'b0;
		while (!ok && n < RESULT_TIMEOUT) begin
			@(posedge i_clk);
			if (o_valid === 1'b1)
				ok = 1'b1;
			n++;
		end
		if (!ok) begin
			$display("timeout: no o_valid within %0d cycles", RESULT_TIMEOUT);
			tb_errors++;
		end
	endtask

	// one request, then a stray write while busy which must be ignored
	task automatic run_divide(input int id, input logic sgn, input div_word_t num,
		input div_word_t den, input div_word_t quo, input logic err,
		input div_flags_t flags, output logic ok);
		wait_idle(ok);
		if (ok) begin
			i_wr          <= 1'b1;
			i_signed      <= sgn;
			i_numerator   <= num;
			i_denominator <= den;
			exp_quotient  <= quo;
			exp_err       <= err;
			exp_flags     <= flags;
			test_id       <= id;
			@(posedge i_clk);
			i_wr <= 1'b0;
			repeat (3) @(posedge i_clk);
			i_wr          <= 1'b1;
			i_numerator   <= ~num;
			i_denominator <= 32'h1;
			@(posedge i_clk);
			i_wr <= 1'b0;
			wait_result(ok);
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		int          fd;
		int          line_no;
		int          n;
		string       line;
		logic [31:0] f_signed;
		logic [31:0] f_num;
		logic [31:0] f_den;
		logic [31:0] f_quo;
		logic [31:0] f_err;
		logic [31:0] f_flags;
		logic        ok;

		i_reset       = 1'b1;
		i_wr          = 1'b0;
		i_signed      = 1'b0;
		i_numerator   = '0;
		i_denominator = '0;
		exp_quotient  = '0;
		exp_err       = 1'b0;
		exp_flags     = '0;
		test_id       = 0;
		tb_errors     = 0;
		vectors       = 0;
		aborted       = 1'b0;

		repeat (2) @(posedge i_clk);
		i_reset <= 1'b0;
		check_reset_quiet();

		fd = $fopen("tb/div_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file tb/div_stimulus.txt");
			tb_errors++;
			aborted = 1'b1;
		end

		// the test name of a vector is its line number in the file
		line_no = 0;
		while (!aborted && !$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			line_no++;
			if (line.len() < 2 || line.substr(0, 1) == "//")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h", f_signed, f_num, f_den,
				f_quo, f_err, f_flags);
			if (n != 6) begin
				$display("line %0d of the stimulus file is not a valid vector", line_no);
				tb_errors++;
				continue;
			end
			run_divide(line_no, f_signed[0], f_num, f_den, f_quo, f_err[0],
				f_flags[2:0], ok);
			vectors++;
			if (!ok)
				aborted = 1'b1;
		end
		if (fd != 0)
			$fclose(fd);

		// give a stray result from the last stray write time to show up
		repeat (`DIV_BW + 8) @(posedge i_clk);

		assert_errors = div_unit_inst.asserts_inst.fail_count;
		$display("errors: checker %0d, testbench %0d, assertions %0d; results %0d of %0d",
			chk_errors, tb_errors, assert_errors, chk_results, vectors);
		if (chk_errors == 0 && tb_errors == 0 && assert_errors == 0 && vectors > 0
				&& chk_results == vectors && !aborted) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- div_unit.f
+incdir+src
src/div_pkg.sv
src/div_ifs.sv
src/div_operand_prep.sv
src/div_shift_sub.sv
src/div_result_fmt.sv
src/div_unit.sv
tb/div_unit_asserts.sv
tb/div_checker.sv
tb/tb_div_unit.sv

//--- run_sim.sh
#!/bin/sh
# build the divide unit testbench with Verilator, run it into sim.log
# and decide the outcome from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module tb_div_unit -f div_unit.f -o tb_div_unit \
	&& ./obj_dir/tb_div_unit +verilator+error+limit+1000 2>&1 | tee sim.log \
	&& grep -q "^Simulation completed successfully$" sim.log \
	&& echo "run passed" \
	|| { echo "run failed, see sim.log"; exit 1; }

//--- tb/div_stimulus.txt
// signed numerator denominator quotient err flags, one divide per line, all hex
// flags bit 0 is zero, bit 1 is negative, bit 2 is overflow
0 00000064 00000007 0000000E 0 0
0 FFFFFFFF 00000001 FFFFFFFF 0 2
0 00000005 0000000A 00000000 0 1
0 FFFFFFFF FFFFFFFF 00000001 0 0
0 80000000 00000002 40000000 0 0
0 12345678 00001000 00012345 0 0
0 FFFFFFFE 00000003 55555554 0 0
0 00000007 00000007 00000001 0 0
0 80000000 FFFFFFFF 00000000 0 1
1 FFFFFF9C 00000007 FFFFFFF2 0 2
1 00000064 FFFFFFF9 FFFFFFF2 0 2
1 FFFFFF9C FFFFFFF9 0000000E 0 0
1 00000064 00000007 0000000E 0 0
1 FFFFFFF9 00000064 00000000 0 1
1 80000000 00000001 80000000 0 2
1 80000000 00000002 C0000000 0 2
1 7FFFFFFF FFFFFFFF 80000001 0 2
1 00000000 00000005 00000000 0 1
0 00000064 00000000 00000000 1 1
1 FFFFFF9C 00000000 00000000 1 1
0 00000000 00000000 00000000 1 1
1 80000000 FFFFFFFF 80000000 0 6
